/* harnessLink.f */
harnessPkg.sv
commandSerializer.sv
byteFifo.sv
uartTx.sv
uartRx.sv
wordAssembler.sv
harnessLink.sv
harnessLink_tb.sv

/* runSim.sh */
#!/bin/sh
# Verilator build and run of the harnessLink loopback testbench

cd "$(dirname "$0")" || exit 1

LOG=runSim.log
BUILD=obj_dir

verilator --binary --timing -f harnessLink.f --top-module harnessLink_tb \
	-Mdir "$BUILD" -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "No result line in $LOG"
	exit 1
fi
exit 0

/* harnessLink_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module harnessLink_tb;

	import harnessPkg::*;

	localparam int ClocksPerBit = 8;
	localparam int ClkPeriod = 10;
	localparam int ResetCycles = 8;
	localparam int NumCmds = 8;
	localparam int CmdBytes = CmdWidth / ByteWidth;
	localparam int NumWords = NumCmds * CmdWidth / RespWidth;
	localparam int QuietCycles = 200;
	// Ten bit periods per character and twice that for margin
	localparam int WatchdogNs = NumCmds * CmdBytes * 10 * ClocksPerBit * ClkPeriod * 2;

	logic                 sys_clk_p;
	logic                 reset;
	logic [CmdWidth-1:0]  cmdData;
	logic                 cmdValid;
	logic                 cmdReady;
	logic                 uartTxd;
	logic                 uartRxd;
	logic [RespWidth-1:0] respData;
	logic                 respValid;

	// Command table
	harnessCmd_e          tblOp [NumCmds];
	logic [31:0]          tblAddr [NumCmds];
	logic [31:0]          tblBase [NumCmds];
	logic [31:0]          tblDelay [NumCmds];

	logic [ByteWidth-1:0] byteQ [$];
	logic [RespWidth-1:0] expQ [$];
	logic [RespWidth-1:0] expWord;
	int                   errors;
	int                   respCount;
	int unsigned          gap;

	harnessLink #(
		.ClocksPerBit(ClocksPerBit),
		.FifoDepth(16),
		.MsbFirst(1)
	) dut (
		.sys_clk_p(sys_clk_p),
		.reset(reset),
		.cmdData(cmdData),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.uartTxd(uartTxd),
		.uartRxd(uartRxd),
		.respData(respData),
		.respValid(respValid)
	);

	// Serial loopback
	assign uartRxd = uartTxd;

	always #(ClkPeriod / 2) sys_clk_p = ~sys_clk_p;

	task automatic checkWord(input string name, input logic [RespWidth-1:0] expected,
		input logic [RespWidth-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	// ----------------------------------------------------------
	// Scoreboard sampled mid-cycle where the pulse is stable
	// ----------------------------------------------------------
	always @(negedge sys_clk_p) begin
		if (!reset && respValid) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("Extra response word %h at %0t with none expected", respData, $time);
			end else begin
				expWord = expQ.pop_front();
				checkWord("respData", expWord, respData);
			end
			respCount++;
		end
	end

	// Watchdog
	initial begin
		#(WatchdogNs);
		$display("Watchdog expired at %0t: responses stopped arriving (%0d of %0d)",
			$time, respCount, NumWords);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		sys_clk_p = 1'b0;
		reset = 1'b1;
		cmdData = '0;
		cmdValid = 1'b0;
		errors = 0;
		respCount = 0;
		void'($urandom(32'h504a));

		// ----------------------------------------------------------
		// Fill, linear, update and read of 0xdead, then random entries
		// ----------------------------------------------------------
		tblOp[0] = cmdFill;
		tblAddr[0] = 32'h0000_00a5;
		tblBase[0] = 32'h1000_0000;
		tblDelay[0] = 32'h0000_0040;
		tblOp[1] = cmdLinear;
		tblAddr[1] = 32'h0000_0000;
		tblBase[1] = 32'd64;
		tblDelay[1] = 32'd4;
		tblOp[2] = cmdUpdate;
		tblAddr[2] = 32'h0000_dead;
		tblBase[2] = 32'hcafe_f00d;
		tblDelay[2] = 32'd0;
		tblOp[3] = cmdRead;
		tblAddr[3] = 32'h0000_dead;
		tblBase[3] = 32'd0;
		tblDelay[3] = 32'd0;
		tblOp[4] = cmdStart;
		tblOp[5] = cmdUpdate;
		tblOp[6] = cmdRead;
		tblOp[7] = cmdLinear;
		for (int i = 4; i < NumCmds; i++) begin
			tblAddr[i] = $urandom;
			tblBase[i] = $urandom;
			tblDelay[i] = $urandom;
		end

		// Expected stream holds the opcode then each field most significant byte first
		for (int i = 0; i < NumCmds; i++) begin
			byteQ.push_back(tblOp[i]);
			for (int k = 3; k >= 0; k--) begin
				byteQ.push_back(tblAddr[i][8*k +: 8]);
			end
			for (int k = 3; k >= 0; k--) begin
				byteQ.push_back(tblBase[i][8*k +: 8]);
			end
			for (int k = 3; k >= 0; k--) begin
				byteQ.push_back(tblDelay[i][8*k +: 8]);
			end
		end
		// First received byte lands on top of each word
		for (int w = 0; w < NumWords; w++) begin
			expQ.push_back({byteQ[4*w], byteQ[4*w+1], byteQ[4*w+2], byteQ[4*w+3]});
		end

		// Reset state checked during and just after reset
		repeat (ResetCycles) begin
			@(negedge sys_clk_p);
			checkBit("uartTxd", 1'b1, uartTxd);
			checkBit("respValid", 1'b0, respValid);
			checkBit("cmdReady", 1'b1, cmdReady);
		end
		@(posedge sys_clk_p);
		reset <= 1'b0;
		@(negedge sys_clk_p);
		checkBit("uartTxd", 1'b1, uartTxd);
		checkBit("respValid", 1'b0, respValid);
		checkBit("cmdReady", 1'b1, cmdReady);

		// ----------------------------------------------------------
		// Stimulus loop holding valid until cmdReady takes it
		// ----------------------------------------------------------
		for (int i = 0; i < NumCmds; i++) begin
			@(posedge sys_clk_p);
			cmdData <= {tblOp[i], tblAddr[i], tblBase[i], tblDelay[i]};
			cmdValid <= 1'b1;
			@(negedge sys_clk_p);
			while (!cmdReady) begin
				@(negedge sys_clk_p);
			end
			// Accepted on this edge
			@(posedge sys_clk_p);
			cmdValid <= 1'b0;
			gap = $urandom % 4;
			repeat (gap) @(posedge sys_clk_p);
		end

		while (respCount < NumWords) begin
			@(negedge sys_clk_p);
		end

		// Quiet period with the line idle and no surplus words
		repeat (QuietCycles) begin
			@(negedge sys_clk_p);
			checkBit("uartTxd", 1'b1, uartTxd);
			checkBit("cmdReady", 1'b1, cmdReady);
		end

		if (respCount != NumWords) begin
			errors++;
			$display("Wrong number of response words: %0d received, %0d sent", respCount,
				NumWords);
		end

		$display("Errors: %0d, response words: %0d of %0d", errors, respCount, NumWords);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* harnessLink.sv */
`timescale 1ns/1ps
`default_nettype none

module harnessLink #(
	parameter int ClocksPerBit = harnessPkg::DefClocksPerBit,
	parameter int FifoDepth = 16,
	parameter int MsbFirst = 1
) (
	input  wire                              sys_clk_p,
	input  wire                              reset,
	input  wire [harnessPkg::CmdWidth-1:0]   cmdData,
	input  wire                              cmdValid,
	output logic                             cmdReady,
	output logic                             uartTxd,
	input  wire                              uartRxd,
	output logic [harnessPkg::RespWidth-1:0] respData,
	output logic                             respValid
);

	import harnessPkg::*;

	logic [ByteWidth-1:0] txByte;
	logic                 txByteValid;
	logic                 txByteReady;
	logic [ByteWidth-1:0] fifoByte;
	logic                 fifoValid;
	logic                 fifoReady;
	logic [ByteWidth-1:0] rxByte;
	logic                 rxByteValid;

	// ----------------------------------------------------------
	// Transmit chain, command to bytes to serial line
	// ----------------------------------------------------------
	commandSerializer #(
		.MsbFirst(MsbFirst)
	) serializer (
		.sys_clk_p(sys_clk_p),
		.reset(reset),
		.cmdData(cmdData),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.txByte(txByte),
		.txByteValid(txByteValid),
		.txByteReady(txByteReady)
	);

	byteFifo #(
		.FifoDepth(FifoDepth)
	) txFifo (
		.sys_clk_p(sys_clk_p),
		.reset(reset),
		.inByte(txByte),
		.inValid(txByteValid),
		.inReady(txByteReady),
		.outByte(fifoByte),
		.outValid(fifoValid),
		.outReady(fifoReady)
	);

	uartTx #(
		.ClocksPerBit(ClocksPerBit)
	) transmitter (
		.sys_clk_p(sys_clk_p),
		.reset(reset),
		.txData(fifoByte),
		.txValid(fifoValid),
		.txReady(fifoReady),
		.txd(uartTxd)
	);

	// ----------------------------------------------------------
	// Receive chain, no back-pressure
	// ----------------------------------------------------------
	uartRx #(
		.ClocksPerBit(ClocksPerBit)
	) receiver (
		.sys_clk_p(sys_clk_p),
		.reset(reset),
		.rxd(uartRxd),
		.rxData(rxByte),
		.rxValid(rxByteValid)
	);

	wordAssembler assembler (
		.sys_clk_p(sys_clk_p),
		.reset(reset),
		.inByte(rxByte),
		.inValid(rxByteValid),
		.respData(respData),
		.respValid(respValid)
	);

endmodule

`default_nettype wire

/* wordAssembler.sv */
`timescale 1ns/1ps
`default_nettype none

module wordAssembler (
	input  wire                              sys_clk_p,
	input  wire                              reset,
	input  wire [harnessPkg::ByteWidth-1:0]  inByte,
	input  wire                              inValid,
	output logic [harnessPkg::RespWidth-1:0] respData,
	output logic                             respValid
);

	import harnessPkg::*;

	localparam int BytesPerWord = RespWidth / ByteWidth;
	localparam int CountWidth = $clog2(BytesPerWord);

	// Holds every byte of a word but the last
	logic [RespWidth-ByteWidth-1:0] partial;
	logic [CountWidth-1:0]          byteCount;
	logic                           lastByte;

	assign lastByte = inValid && (byteCount == CountWidth'(BytesPerWord - 1));

	// Count modulo the bytes per word
	always_ff @(posedge sys_clk_p) begin
		if (reset) begin
			byteCount <= '0;
			respValid <= 1'b0;
		end else begin
			respValid <= lastByte;
			if (inValid) begin
				byteCount <= byteCount + 1'b1;
			end
		end
	end

	// Earlier bytes drift up, so the first ends most significant
	always_ff @(posedge sys_clk_p) begin
		if (inValid) begin
			partial <= {partial[RespWidth-2*ByteWidth-1:0], inByte};
		end
		if (lastByte) begin
			respData <= {partial, inByte};
		end
	end

endmodule

`default_nettype wire

/* uartRx.sv */
`timescale 1ns/1ps
`default_nettype none

module uartRx #(
	parameter int ClocksPerBit = harnessPkg::DefClocksPerBit
) (
	input  wire                              sys_clk_p,
	input  wire                              reset,
	input  wire                              rxd,
	output logic [harnessPkg::ByteWidth-1:0] rxData,
	output logic                             rxValid
);

	import harnessPkg::*;

	localparam int CountWidth = (ClocksPerBit > 1) ? $clog2(ClocksPerBit) : 1;
	localparam int IndexWidth = $clog2(ByteWidth);
	localparam int HalfBit = (ClocksPerBit > 1) ? ClocksPerBit / 2 : 1;

	uartState_e            state;
	logic [CountWidth-1:0] bitCount;
	logic [IndexWidth-1:0] bitIndex;
	logic [ByteWidth-1:0]  shiftReg;
	logic                  rxdMeta;
	logic                  rxdSync;
	logic                  rxdLast;
	logic                  bitDone;
	logic                  halfDone;

	// ----------------------------------------------------------
	// Input synchronizer and edge history
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (reset) begin
			rxdMeta <= 1'b1;
			rxdSync <= 1'b1;
			rxdLast <= 1'b1;
		end else begin
			rxdMeta <= rxd;
			rxdSync <= rxdMeta;
			rxdLast <= rxdSync;
		end
	end

	assign bitDone = (bitCount == CountWidth'(ClocksPerBit - 1));
	assign halfDone = (bitCount == CountWidth'(HalfBit - 1));

	// Shifter is frozen from the last data bit until the next frame
	assign rxData = shiftReg;

	// ----------------------------------------------------------
	// Frame FSM
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (reset) begin
			state <= uartIdle;
			bitCount <= '0;
			bitIndex <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			bitCount <= bitDone ? '0 : bitCount + 1'b1;
			case (state)
				uartIdle: begin
					bitCount <= '0;
					// Falling edge opens a frame
					if (rxdLast && !rxdSync) begin
						state <= uartStart;
					end
				end
				uartStart: begin
					// Middle of start bit, glitches go back to idle
					if (halfDone) begin
						bitCount <= '0;
						bitIndex <= '0;
						state <= rxdSync ? uartIdle : uartData;
					end
				end
				uartData: begin
					if (bitDone) begin
						shiftReg <= {rxdSync, shiftReg[ByteWidth-1:1]};
						bitIndex <= bitIndex + 1'b1;
						if (bitIndex == IndexWidth'(ByteWidth - 1)) begin
							state <= uartStop;
						end
					end
				end
				uartStop: begin
					// Low stop bit means a broken frame, byte dropped
					if (bitDone) begin
						rxValid <= rxdSync;
						state <= uartIdle;
					end
				end
				default: state <= uartIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* uartTx.sv */
`timescale 1ns/1ps
`default_nettype none

module uartTx #(
	parameter int ClocksPerBit = harnessPkg::DefClocksPerBit
) (
	input  wire                             sys_clk_p,
	input  wire                             reset,
	input  wire [harnessPkg::ByteWidth-1:0] txData,
	input  wire                             txValid,
	output logic                            txReady,
	output logic                            txd
);

	import harnessPkg::*;

	localparam int CountWidth = (ClocksPerBit > 1) ? $clog2(ClocksPerBit) : 1;
	localparam int IndexWidth = $clog2(ByteWidth);

	uartState_e            state;
	logic [CountWidth-1:0] bitCount;
	logic [IndexWidth-1:0] bitIndex;
	logic [ByteWidth-1:0]  shiftReg;
	logic                  bitDone;

	assign bitDone = (bitCount == CountWidth'(ClocksPerBit - 1));
	assign txReady = (state == uartIdle);

	always_ff @(posedge sys_clk_p) begin
		if (reset) begin
			state <= uartIdle;
			bitCount <= '0;
			bitIndex <= '0;
			txd <= 1'b1;
		end else begin
			bitCount <= bitDone ? '0 : bitCount + 1'b1;
			case (state)
				uartIdle: begin
					bitCount <= '0;
					if (txValid) begin
						// Start bit goes out right away
						shiftReg <= txData;
						txd <= 1'b0;
						state <= uartStart;
					end
				end
				uartStart: begin
					if (bitDone) begin
						txd <= shiftReg[0];
						shiftReg <= shiftReg >> 1;
						bitIndex <= '0;
						state <= uartData;
					end
				end
				uartData: begin
					// LSB first, one bit per period
					if (bitDone) begin
						if (bitIndex == IndexWidth'(ByteWidth - 1)) begin
							txd <= 1'b1;
							state <= uartStop;
						end else begin
							txd <= shiftReg[0];
							shiftReg <= shiftReg >> 1;
							bitIndex <= bitIndex + 1'b1;
						end
					end
				end
				uartStop: begin
					if (bitDone) begin
						state <= uartIdle;
					end
				end
				default: state <= uartIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* byteFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module byteFifo #(
	parameter int FifoDepth = 16
) (
	input  wire                              sys_clk_p,
	input  wire                              reset,
	input  wire [harnessPkg::ByteWidth-1:0]  inByte,
	input  wire                              inValid,
	output logic                             inReady,
	output logic [harnessPkg::ByteWidth-1:0] outByte,
	output logic                             outValid,
	input  wire                              outReady
);

	import harnessPkg::*;

	// Depth is a power of two, so pointers wrap on their own
	localparam int PtrWidth = $clog2(FifoDepth);

	logic [ByteWidth-1:0] mem [FifoDepth];
	logic [PtrWidth-1:0]  wrPtr;
	logic [PtrWidth-1:0]  rdPtr;
	logic [PtrWidth:0]    count;
	logic                 push;
	logic                 pop;

	assign inReady = (count != (PtrWidth + 1)'(FifoDepth));
	assign outValid = (count != '0);
	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	// Head of queue shows without a read cycle
	assign outByte = mem[rdPtr];

	always_ff @(posedge sys_clk_p) begin
		if (push) begin
			mem[wrPtr] <= inByte;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge sys_clk_p) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* commandSerializer.sv */
`timescale 1ns/1ps
`default_nettype none

module commandSerializer #(
	parameter int MsbFirst = 1
) (
	input  wire                            sys_clk_p,
	input  wire                            reset,
	input  wire [harnessPkg::CmdWidth-1:0] cmdData,
	input  wire                            cmdValid,
	output logic                           cmdReady,
	output logic [harnessPkg::ByteWidth-1:0] txByte,
	output logic                           txByteValid,
	input  wire                            txByteReady
);

	import harnessPkg::*;

	localparam int CmdBytes = CmdWidth / ByteWidth;
	localparam int CountWidth = $clog2(CmdBytes + 1);

	harnessCmd_e           cmdOpcode;
	logic [CmdWidth-1:0]   shiftReg;
	logic [CountWidth-1:0] bytesLeft;
	logic                  cmdAccept;
	logic                  byteTaken;

	// Opcode sits in the top byte of the command word
	assign cmdOpcode = harnessCmd_e'(cmdData[CmdWidth-1 -: OpcodeWidth]);

	// New command only once every byte has gone out
	assign cmdReady = (bytesLeft == '0);
	assign cmdAccept = cmdValid && cmdReady;
	assign txByteValid = (bytesLeft != '0);
	assign byteTaken = txByteValid && txByteReady;

	// Offered byte comes from whichever end goes first
	assign txByte = (MsbFirst != 0) ? shiftReg[CmdWidth-1 -: ByteWidth]
		: shiftReg[ByteWidth-1:0];

	// Remaining byte count
	always_ff @(posedge sys_clk_p) begin
		if (reset) begin
			bytesLeft <= '0;
		end else if (cmdAccept) begin
			bytesLeft <= CountWidth'(CmdBytes);
		end else if (byteTaken) begin
			bytesLeft <= bytesLeft - 1'b1;
		end
	end

	// Payload shifter, moves one byte per transfer
	always_ff @(posedge sys_clk_p) begin
		if (cmdAccept) begin
			shiftReg <= {cmdOpcode, cmdData[CmdWidth-OpcodeWidth-1:0]};
		end else if (byteTaken) begin
			shiftReg <= (MsbFirst != 0) ? (shiftReg << ByteWidth) : (shiftReg >> ByteWidth);
		end
	end

endmodule

`default_nettype wire

/* harnessPkg.sv */
`default_nettype none

package harnessPkg;

	// ----------------------------------------------------------
	// Command and character widths
	// ----------------------------------------------------------
	localparam int OpcodeWidth = 8;
	// Address/seed, data base/count and delay/offset are all one size
	localparam int FieldWidth = 32;
	localparam int CmdWidth = OpcodeWidth + 3 * FieldWidth;
	localparam int ByteWidth = 8;
	localparam int RespWidth = 32;

	// Bit period in clocks unless the top level overrides it
	localparam int DefClocksPerBit = 8;

	// ----------------------------------------------------------
	// Harness opcodes, top byte of a command
	// ----------------------------------------------------------
	typedef enum logic [OpcodeWidth-1:0] {
		cmdUpdate = 8'h00,
		cmdRead   = 8'h02,
		cmdFill   = 8'h10,
		cmdLinear = 8'h11,
		cmdStart  = 8'hff
	} harnessCmd_e;

	// Shared by the transmit and receive engines
	typedef enum logic [1:0] {
		uartIdle,
		uartStart,
		uartData,
		uartStop
	} uartState_e;

endpackage

`default_nettype wire
